/* compile.f */
logic/fetch_pkg.sv
logic/icache.sv
logic/fetch_ifu.sv
logic/fetch_top.sv
sim/fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim > sim.log
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

/* sim/fetch_golden.txt */
// Header rows: number of image rows, number of test rows.
// Image rows: address, data. Test rows: name (ASCII), pc, expected inst, expected fault.
0000000C
0000000A
// SDRAM line at A0000000.
A0000000 00000013
A0000004 00100093
A0000008 00200113
A000000C 00308193
// Plain region line at 00001040.
00001040 06400213
00001044 0C800293
00001048 12C00313
0000104C 19000393
// SDRAM line at A0000100, same index as the line at A0000000.
A0000100 00A50533
A0000104 00B585B3
A0000108 40C60633
A000010C 00D6F6B3
// Tests.
5344524D A0000008 00200113 00000000
53444854 A000000C 00308193 00000000
53474C4D 00001044 0C800293 00000000
53474854 00001040 06400213 00000000
53474832 0000104C 19000393 00000000
464C5431 F0000020 00000000 00000001
464C5432 F0000020 00000000 00000001
45564354 A0000104 00B585B3 00000000
5245464C A0000000 00000013 00000000
48495433 00001048 12C00313 00000000

/* sim/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] FAULT_BASE = 32'hF000_0000; // Slave answers SLVERR from here up.

    logic                         clk = 1'b0;
    logic                         rst = 1'b1;
    logic                         pc_valid = 1'b0;
    logic [fetch_pkg::XLEN-1:0]   pc = '0;
    logic                         pc_ready;
    logic                         rsp_valid;
    fetch_pkg::fetch_rsp_t        rsp;
    logic                         rsp_ready = 1'b1;
    logic                         ar_valid;
    fetch_pkg::axi_ar_t           ar;
    logic                         ar_ready = 1'b0;
    logic                         r_valid = 1'b0;
    fetch_pkg::axi_r_t            r = '0;
    logic                         r_ready;

    logic [31:0] golden [0:255];
    int          n_img;
    int          n_test;

    // Every AR handshake is logged here at the rising edge.
    logic [31:0] ar_addr_log  [0:255];
    logic [7:0]  ar_len_log   [0:255];
    logic [1:0]  ar_burst_log [0:255];
    logic [3:0]  ar_id_log    [0:255];
    logic [2:0]  ar_size_log  [0:255];
    int          ar_count = 0;
    int          r_count = 0;
    int          rsp_count = 0;

    logic [31:0] rng = 32'h68f3;
    logic        stall = 1'b0;
    logic        busy = 1'b0;
    logic [31:0] cur_addr = '0;
    logic [3:0]  cur_id = '0; // R beats carry the id of the read they answer.
    logic [8:0]  beats_left = '0;
    logic [1:0]  delay = '0;
    int          ar_served = 0;
    int          r_seen = 0;

    logic        model_valid [0:15]; // Which line base each cache index should hold.
    logic [31:0] model_base  [0:15];

    int          test_pass = 0;
    int          test_fail = 0;
    int          test_errs = 0;
    logic        timed_out = 1'b0;

    fetch_top i_fetch_top (
        .clk       (clk),
        .rst       (rst),
        .pc_valid  (pc_valid),
        .pc        (pc),
        .pc_ready  (pc_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] golden_word(input int pos);
        return golden[pos[7:0]];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        for (int k = 0; k < n_img; k++) begin
            if (golden_word(2 + 2 * k) == addr) begin
                return golden_word(3 + 2 * k);
            end
        end
        return addr ^ 32'hDEAD_BEEF; // Words outside the image.
    endfunction

    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            ar_addr_log[ar_count[7:0]]  <= ar.addr;
            ar_len_log[ar_count[7:0]]   <= ar.len;
            ar_burst_log[ar_count[7:0]] <= ar.burst;
            ar_id_log[ar_count[7:0]]    <= ar.id;
            ar_size_log[ar_count[7:0]]  <= ar.size;
            ar_count                    <= ar_count + 1;
        end
        if (r_valid && r_ready) begin
            r_count <= r_count + 1;
        end
        if (rsp_valid && rsp_ready) begin
            rsp_count <= rsp_count + 1;
        end
    end

    // AXI slave. It serves one logged AR at a time, beat by beat.
    always @(negedge clk) begin
        rng = xorshift(rng);
        if (r_seen != r_count) begin
            r_seen     = r_count;
            r_valid    = 1'b0;
            cur_addr   = cur_addr + 32'd4;
            beats_left = beats_left - 9'd1;
            delay      = rng[1:0];
            if (beats_left == 9'd0) begin
                busy = 1'b0;
            end
        end
        if (!busy && ar_served != ar_count) begin
            cur_addr   = ar_addr_log[ar_served[7:0]];
            cur_id     = ar_id_log[ar_served[7:0]];
            beats_left = {1'b0, ar_len_log[ar_served[7:0]]} + 9'd1;
            ar_served  = ar_served + 1;
            delay      = rng[1:0];
            busy       = 1'b1;
        end
        if (busy && !r_valid) begin
            if (delay == 2'd0) begin
                r_valid = 1'b1;
                r = '{data: mem_word(cur_addr),
                      resp: (cur_addr >= FAULT_BASE) ? 2'b10 : 2'b00,
                      last: (beats_left == 9'd1),
                      id:   cur_id};
            end else begin
                delay = delay - 2'd1;
            end
        end
        ar_ready  = stall ? (rng[2] | rng[3]) : 1'b1;
        rsp_ready = stall ? (rng[4] | rng[5]) : 1'b1;
    end

    task automatic report_error(input string test, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        $display("error: %s %s expected %h actual %h", test, what, expected, actual);
        test_errs = test_errs + 1;
    endtask

    task automatic finish_test(input string test);
        if (test_errs == 0) begin
            $display("pass: %s", test);
            test_pass = test_pass + 1;
        end else begin
            $display("fail: %s", test);
            test_fail = test_fail + 1;
        end
    endtask

    task automatic note_timeout(input string test, input string what);
        $display("%s: no %s within %0d cycles", test, what, WAIT_LIMIT);
        timed_out = 1'b1;
        test_errs = test_errs + 1;
        finish_test(test);
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        pc_valid = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    task automatic check_reset();
        test_errs = 0;
        if (pc_ready !== 1'b1) report_error("reset", "pc_ready", 32'd1, 32'(pc_ready));
        if (rsp_valid !== 1'b0) report_error("reset", "rsp_valid", 32'd0, 32'(rsp_valid));
        if (ar_valid !== 1'b0) report_error("reset", "ar_valid", 32'd0, 32'(ar_valid));
        if (r_ready !== 1'b0) report_error("reset", "r_ready", 32'd0, 32'(r_ready));
        finish_test("reset");
    endtask

    task automatic run_fetch(input int idx, input string phase);
        logic [31:0] name;
        logic [31:0] tpc;
        logic [31:0] exp_inst;
        logic [31:0] exp_fault;
        logic [31:0] base;
        logic [31:0] exp_addr;
        logic [7:0]  exp_len;
        logic [3:0]  index;
        logic        cached;
        logic        sdram;
        int          exp_ars;
        int          ar_before;
        int          rsp_before;
        int          waited;
        string       test;
        name      = golden_word(2 + 2 * n_img + 4 * idx);
        tpc       = golden_word(3 + 2 * n_img + 4 * idx);
        exp_inst  = golden_word(4 + 2 * n_img + 4 * idx);
        exp_fault = golden_word(5 + 2 * n_img + 4 * idx);
        test      = $sformatf("%s %s", phase, name);
        test_errs = 0;
        base      = {tpc[31:4], 4'h0};
        index     = tpc[7:4];
        cached    = model_valid[index] && (model_base[index] == base);
        sdram     = (base >= fetch_pkg::SDRAM_BASE) && (base <= fetch_pkg::SDRAM_END);
        exp_len   = sdram ? 8'd3 : 8'd0;
        if (cached) exp_ars = 0;
        else if (sdram || base >= FAULT_BASE) exp_ars = 1; // An error ends single reads at once.
        else exp_ars = fetch_pkg::LINE_WORDS;

        waited = 0;
        while (!pc_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pc_ready) begin
            note_timeout(test, "pc_ready");
            return;
        end
        ar_before  = ar_count;
        rsp_before = rsp_count;
        pc_valid   = 1'b1;
        pc         = tpc;
        @(negedge clk);
        pc_valid = 1'b0;

        waited = 0;
        while (!rsp_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            note_timeout(test, "rsp_valid");
            return;
        end
        if (cached && waited != 2) report_error(test, "hit latency", 32'd2, 32'(waited));
        if (rsp.inst !== exp_inst) report_error(test, "inst", exp_inst, rsp.inst);
        if (rsp.fault !== exp_fault[0]) report_error(test, "fault", exp_fault, 32'(rsp.fault));

        waited = 0;
        while (rsp_count == rsp_before && waited < WAIT_LIMIT) begin
            if (pc_ready) report_error(test, "pc_ready while held", 32'd0, 32'd1);
            @(negedge clk);
            waited++;
        end
        if (rsp_count == rsp_before) begin
            note_timeout(test, "response handshake");
            return;
        end

        if (ar_count - ar_before != exp_ars) begin
            report_error(test, "ar count", 32'(exp_ars), 32'(ar_count - ar_before));
        end else begin
            for (int k = 0; k < exp_ars; k++) begin
                exp_addr = sdram ? base : base + 32'(4 * k);
                if (ar_addr_log[8'(ar_before + k)] !== exp_addr)
                    report_error(test, "ar addr", exp_addr, ar_addr_log[8'(ar_before + k)]);
                if (ar_len_log[8'(ar_before + k)] !== exp_len)
                    report_error(test, "ar len", 32'(exp_len), 32'(ar_len_log[8'(ar_before + k)]));
                if (sdram && ar_burst_log[8'(ar_before + k)] !== 2'b01)
                    report_error(test, "ar burst", 32'd1, 32'(ar_burst_log[8'(ar_before + k)]));
                if (ar_id_log[8'(ar_before + k)] !== fetch_pkg::FETCH_ID)
                    report_error(test, "ar id", 32'(fetch_pkg::FETCH_ID),
                                 32'(ar_id_log[8'(ar_before + k)]));
                if (ar_size_log[8'(ar_before + k)] !== 3'd2) // Four bytes per beat.
                    report_error(test, "ar size", 32'd2, 32'(ar_size_log[8'(ar_before + k)]));
            end
        end
        if (!cached && !exp_fault[0]) begin
            model_valid[index] = 1'b1;
            model_base[index]  = base;
        end
        finish_test(test);
    endtask

    initial begin
        $readmemh("sim/fetch_golden.txt", golden);
        n_img  = int'(golden[0]);
        n_test = int'(golden[1]);
        apply_reset();
        check_reset();
        for (int i = 0; i < n_test && !timed_out; i++) begin
            run_fetch(i, "plain");
        end
        // Second pass starts from a cold cache with both channels stalling.
        if (!timed_out) begin
            apply_reset();
            stall = 1'b1;
            for (int i = 0; i < n_test && !timed_out; i++) begin
                run_fetch(i, "stall");
            end
        end
        $display("tests passed %0d failed %0d", test_pass, test_fail);
        if (test_fail == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pc_valid,
    input  logic [fetch_pkg::XLEN-1:0]    pc,
    output logic                          pc_ready,
    output logic                          rsp_valid,
    output fetch_pkg::fetch_rsp_t         rsp,
    input  logic                          rsp_ready,
    output logic                          ar_valid,
    output fetch_pkg::axi_ar_t            ar,
    input  logic                          ar_ready,
    input  logic                          r_valid,
    input  fetch_pkg::axi_r_t             r,
    output logic                          r_ready
);

    logic                          lookup_valid;
    logic [fetch_pkg::XLEN-1:0]    lookup_addr;
    logic                          hit;
    logic [fetch_pkg::XLEN-1:0]    hit_inst;
    logic                          miss_req;
    fetch_pkg::refill_req_t        miss;
    logic                          fill_valid;
    fetch_pkg::refill_rsp_t        fill;
    logic [fetch_pkg::XLEN-1:0]    fill_inst;

    fetch_ifu i_fetch_ifu (
        .clk          (clk),
        .rst          (rst),
        .pc_valid     (pc_valid),
        .pc           (pc),
        .pc_ready     (pc_ready),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .r_ready      (r_ready),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_inst     (hit_inst),
        .miss_req     (miss_req),
        .miss         (miss),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .fill_inst    (fill_inst)
    );

    icache i_icache (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_inst     (hit_inst),
        .miss_req     (miss_req),
        .miss         (miss),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .fill_inst    (fill_inst)
    );

endmodule

/* logic/fetch_ifu.sv */
`timescale 1ns/1ps

module fetch_ifu (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pc_valid,
    input  logic [fetch_pkg::XLEN-1:0]    pc,
    output logic                          pc_ready,
    output logic                          rsp_valid,
    output fetch_pkg::fetch_rsp_t         rsp,
    input  logic                          rsp_ready,
    output logic                          ar_valid,
    output fetch_pkg::axi_ar_t            ar,
    input  logic                          ar_ready,
    input  logic                          r_valid,
    input  fetch_pkg::axi_r_t             r,
    output logic                          r_ready,
    output logic                          lookup_valid,
    output logic [fetch_pkg::XLEN-1:0]    lookup_addr,
    input  logic                          hit,
    input  logic [fetch_pkg::XLEN-1:0]    hit_inst,
    input  logic                          miss_req,
    input  fetch_pkg::refill_req_t        miss,
    output logic                          fill_valid,
    output fetch_pkg::refill_rsp_t        fill,
    input  logic [fetch_pkg::XLEN-1:0]    fill_inst
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } state_t;

    state_t state;

    logic [fetch_pkg::XLEN-1:0]          pc_q;
    logic                                lookup_sent;
    logic                                refill_started;
    logic                                burst_q;
    logic [fetch_pkg::OFFSET_BITS-3:0]   beat_cnt;
    logic [fetch_pkg::LINE_BITS-1:0]     line_q;
    logic                                fault_q;
    logic                                done_q;

    logic accept;
    logic launch;
    logic in_sdram;
    logic r_hs;
    logic r_bad;
    logic last_beat;

    assign pc_ready     = (state == IDLE);
    assign rsp_valid    = (state == RESPOND);
    assign lookup_valid = (state == LOOKUP) && !lookup_sent;
    assign lookup_addr  = pc_q;

    assign accept   = pc_valid && pc_ready;
    assign in_sdram = (miss.line_addr >= fetch_pkg::SDRAM_BASE) &&
                      (miss.line_addr <= fetch_pkg::SDRAM_END);
    assign launch   = (state == REFILL) && !refill_started && miss_req;

    assign r_hs  = r_valid && r_ready;
    assign r_bad = (r.resp != fetch_pkg::RESP_OKAY);
    // A burst must be drained to its last beat even after an error.
    assign last_beat = burst_q ? r.last : (r_bad || (&beat_cnt));

    assign fill = '{line: line_q, fault: fault_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= IDLE;
            lookup_sent    <= 1'b0;
            refill_started <= 1'b0;
            ar_valid       <= 1'b0;
            r_ready        <= 1'b0;
            beat_cnt       <= '0;
            fault_q        <= 1'b0;
            done_q         <= 1'b0;
            fill_valid     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state       <= LOOKUP;
                        lookup_sent <= 1'b0;
                    end
                end
                LOOKUP: begin
                    lookup_sent <= 1'b1;
                    if (lookup_sent) begin
                        state          <= hit ? RESPOND : REFILL;
                        refill_started <= 1'b0;
                    end
                end
                REFILL: begin
                    if (launch) begin
                        refill_started <= 1'b1;
                        ar_valid       <= 1'b1;
                        beat_cnt       <= '0;
                        fault_q        <= 1'b0;
                    end
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (r_hs) begin
                        if (r_bad) begin
                            fault_q <= 1'b1;
                        end
                        if (last_beat) begin
                            r_ready <= 1'b0;
                            done_q  <= 1'b1;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            if (!burst_q) begin // Next single read goes out.
                                r_ready  <= 1'b0;
                                ar_valid <= 1'b1;
                            end
                        end
                    end
                    if (done_q) begin
                        done_q     <= 1'b0;
                        fill_valid <= 1'b1;
                    end
                    if (fill_valid) begin
                        fill_valid <= 1'b0;
                        state      <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= pc;
        end
        if (launch) begin
            burst_q  <= in_sdram;
            ar.addr  <= miss.line_addr;
            ar.id    <= fetch_pkg::FETCH_ID;
            ar.len   <= in_sdram ? 8'(fetch_pkg::LINE_WORDS - 1) : 8'd0;
            ar.size  <= 3'd2;                          // Four bytes per beat.
            ar.burst <= in_sdram ? 2'b01 : 2'b00;      // INCR or FIXED.
        end
        if (r_hs) begin
            if (!r_bad && !fault_q) begin
                line_q[beat_cnt*32 +: 32] <= r.data;
            end
            if (!last_beat && !burst_q) begin
                ar.addr <= {miss.line_addr[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                            beat_cnt + 1'b1, 2'b00};
            end
        end
        if (state == LOOKUP && lookup_sent && hit) begin
            rsp <= '{inst: hit_inst, fault: 1'b0};
        end else if (fill_valid) begin
            rsp <= '{inst: fill.fault ? '0 : fill_inst, fault: fill.fault};
        end
    end

    // The slave may not see the address change before it takes it.
    assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> $stable(ar));

    assert property (@(posedge clk) disable iff (rst)
        r_valid && r_ready |-> r.id == fetch_pkg::FETCH_ID);

endmodule

/* logic/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          lookup_valid,
    input  logic [fetch_pkg::XLEN-1:0]    lookup_addr,
    output logic                          hit,
    output logic [fetch_pkg::XLEN-1:0]    hit_inst,
    output logic                          miss_req,
    output fetch_pkg::refill_req_t        miss,
    input  logic                          fill_valid,
    input  fetch_pkg::refill_rsp_t        fill,
    output logic [fetch_pkg::XLEN-1:0]    fill_inst
);

    localparam int LINES = 2 ** fetch_pkg::INDEX_BITS;

    logic [fetch_pkg::TAG_BITS-1:0]   tag_mem  [LINES];
    logic [fetch_pkg::LINE_BITS-1:0]  data_mem [LINES];
    logic [LINES-1:0]                 valid_q;

    logic [fetch_pkg::XLEN-1:0]          lk_addr_q;
    logic                                lk_valid_q;
    logic [fetch_pkg::INDEX_BITS-1:0]    lk_index;
    logic [fetch_pkg::TAG_BITS-1:0]      lk_tag;
    logic [fetch_pkg::OFFSET_BITS-3:0]   lk_word;
    logic                                lk_miss;

    function automatic logic [fetch_pkg::XLEN-1:0] select_word(
        input logic [fetch_pkg::LINE_BITS-1:0]   line,
        input logic [fetch_pkg::OFFSET_BITS-3:0] sel
    );
        return line[sel*fetch_pkg::XLEN +: fetch_pkg::XLEN];
    endfunction

    assign lk_index = lk_addr_q[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
    assign lk_tag   = lk_addr_q[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];
    assign lk_word  = lk_addr_q[fetch_pkg::OFFSET_BITS-1:2];

    assign hit       = lk_valid_q && valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
    assign lk_miss   = lk_valid_q && !hit;
    assign hit_inst  = select_word(data_mem[lk_index], lk_word);
    // The word is taken straight from the incoming line so the IFU
    // does not have to wait for the array write.
    assign fill_inst = select_word(fill.line, lk_word);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q    <= '0;
            lk_valid_q <= 1'b0;
            miss_req   <= 1'b0;
        end else begin
            lk_valid_q <= lookup_valid;
            if (lk_miss) begin
                miss_req <= 1'b1;
            end else if (fill_valid) begin
                miss_req <= 1'b0;
            end
            if (fill_valid && !fill.fault) begin
                valid_q[lk_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            lk_addr_q <= lookup_addr;
        end
        if (lk_miss) begin
            miss.line_addr <= {lk_addr_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                               {fetch_pkg::OFFSET_BITS{1'b0}}};
        end
        if (fill_valid && !fill.fault) begin // A faulted line stays invalid.
            tag_mem[lk_index]  <= lk_tag;
            data_mem[lk_index] <= fill.line;
        end
    end

    // A refill is only ever answered for a miss this cache asked about.
    assert property (@(posedge clk) disable iff (rst)
        fill_valid |-> miss_req);

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    localparam int XLEN        = 32;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_BITS   = LINE_WORDS * 32;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS;

    // Only this window is served by the SDRAM controller, which takes bursts.
    localparam logic [XLEN-1:0] SDRAM_BASE = 32'hA000_0000;
    localparam logic [XLEN-1:0] SDRAM_END  = 32'hBFFF_FFFF;

    localparam logic [3:0] FETCH_ID  = 4'h1;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [3:0]      id;
        logic [7:0]      len;
        logic [2:0]      size;
        logic [1:0]      burst;
    } axi_ar_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic [1:0]      resp;
        logic            last;
        logic [3:0]      id;
    } axi_r_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic            fault;
    } fetch_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0] line_addr; // Low OFFSET_BITS are always zero.
    } refill_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] line;
        logic                 fault;
    } refill_rsp_t;

endpackage
